/* flist.f */
+incdir+hdl
hdl/silver_isa_pkg.sv
hdl/silver_mem_pkg.sv
hdl/mem_bus_if.sv
hdl/silver_alu.sv
hdl/operand_fetch.sv
hdl/load_store_unit.sv
hdl/mem_arbiter.sv
hdl/silver_sequencer.sv
hdl/silver_top.sv
test/silver_tb.sv

/* hdl/load_store_unit.sv */
// issues word and byte loads and stores on the data bus and returns load results
`include "silver_macros.svh"

module load_store_unit (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    start,
   input  silver_mem_pkg::lsu_op_t op,
   input  logic [`SILVER_WORD-1:0] a_val,
   input  logic [`SILVER_WORD-1:0] b_val,
   output logic                    done,
   output logic [`SILVER_WORD-1:0] load_data,
   mem_bus_if.requester            bus
);
   localparam int W = `SILVER_WORD;

   logic       store;
   logic       store_byte;
   logic       pending;
   logic       byte_q;
   logic [1:0] lane_q;

   assign store      = op inside {silver_mem_pkg::lsu_store_word, silver_mem_pkg::lsu_store_byte};
   assign store_byte = op == silver_mem_pkg::lsu_store_byte;

   // request goes out in the start cycle
   assign bus.command = !start ? silver_mem_pkg::cmd_none :
                        store  ? silver_mem_pkg::cmd_write : silver_mem_pkg::cmd_read;
   assign bus.addr  = store ? b_val : a_val;
   assign bus.wdata = store_byte ? W'(a_val[7:0]) << {b_val[1:0], 3'b000} : a_val;
   assign bus.wstrb = store_byte ? `SILVER_STRB'(4'b0001 << b_val[1:0]) :
                      store      ? `SILVER_STRB'(4'b1111) : '0;

   assign done      = bus.ready;
   assign load_data = byte_q ? W'(bus.rdata[{lane_q, 3'b000} +: 8]) : bus.rdata;

   always_ff @(posedge clk) begin
      if (rst)
         pending <= 1'b0;
      else if (start)
         pending <= 1'b1;
      else if (bus.ready)
         pending <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (start) begin
         byte_q <= op == silver_mem_pkg::lsu_load_byte;
         lane_q <= a_val[1:0];  // byte lane of the load address
      end
   end

   // arbiter only returns ready to this unit for its own request
   assert property (@(posedge clk) disable iff (rst) bus.ready |-> pending);
endmodule

/* hdl/mem_arbiter.sv */
// joins the fetch and load/store requesters onto the external memory bus, data first
`include "silver_macros.svh"

module mem_arbiter (
   input  logic                      clk,
   input  logic                      rst,
   mem_bus_if.arbiter                fetch_bus,
   mem_bus_if.arbiter                data_bus,
   output silver_mem_pkg::mem_cmd_t  mem_command,
   output logic [`SILVER_WORD-1:0]   mem_addr,
   output logic [`SILVER_WORD-1:0]   mem_wdata,
   output logic [`SILVER_STRB-1:0]   mem_wstrb,
   input  logic                      mem_ready,
   input  logic [`SILVER_WORD-1:0]   mem_rdata
);
   logic grant_data;
   logic busy;
   logic owner_data;  // response belongs to the data requester

   assign grant_data  = data_bus.command != silver_mem_pkg::cmd_none;
   assign mem_command = grant_data ? data_bus.command : fetch_bus.command;
   assign mem_addr    = grant_data ? data_bus.addr    : fetch_bus.addr;
   assign mem_wdata   = grant_data ? data_bus.wdata   : fetch_bus.wdata;
   assign mem_wstrb   = grant_data ? data_bus.wstrb   : fetch_bus.wstrb;

   assign fetch_bus.ready = mem_ready && busy && !owner_data;
   assign data_bus.ready  = mem_ready && busy && owner_data;
   assign fetch_bus.rdata = mem_rdata;
   assign data_bus.rdata  = mem_rdata;

   always_ff @(posedge clk) begin
      if (rst) begin
         busy       <= 1'b0;
         owner_data <= 1'b0;
      end else if (mem_command != silver_mem_pkg::cmd_none) begin
         busy       <= 1'b1;
         owner_data <= grant_data;
      end else if (mem_ready) begin
         busy <= 1'b0;
      end
   end

   assert property (@(posedge clk) disable iff (rst)
      busy |-> mem_command == silver_mem_pkg::cmd_none);
endmodule

/* hdl/mem_bus_if.sv */
// one requester's memory traffic, between a requester and the bus arbiter
`include "silver_macros.svh"

interface mem_bus_if;
   silver_mem_pkg::mem_cmd_t command;
   logic [`SILVER_WORD-1:0]  addr;
   logic [`SILVER_WORD-1:0]  wdata;
   logic [`SILVER_STRB-1:0]  wstrb;
   logic                     ready;  // one cycle pulse, rdata valid with it
   logic [`SILVER_WORD-1:0]  rdata;

   modport requester (
      output command, addr, wdata, wstrb,
      input  ready, rdata
   );

   modport arbiter (
      input  command, addr, wdata, wstrb,
      output ready, rdata
   );
endinterface

/* hdl/operand_fetch.sv */
// register file and operand selection, giving aV, bV and wV for the current instruction
`include "silver_macros.svh"

module operand_fetch (
   input  logic                   clk,
   input  logic                   rst,
   input  silver_isa_pkg::instr_t instr,
   input  logic                   reg_we,
   input  logic [`SILVER_WORD-1:0] reg_wdata,
   output logic [`SILVER_WORD-1:0] a_val,
   output logic [`SILVER_WORD-1:0] b_val,
   output logic [`SILVER_WORD-1:0] w_val
);
   logic [`SILVER_WORD-1:0] regs [`SILVER_REGS];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `SILVER_REGS; i++)
            regs[i] <= '0;
      end else if (reg_we) begin
         regs[instr.r.rw] <= reg_wdata;
      end
   end

   // immediate flag swaps in the sign-extended field
   assign a_val = instr.r.a_imm ? silver_isa_pkg::sext_field(instr.r.ra)
                                : regs[instr.r.ra];
   assign b_val = instr.r.b_imm ? silver_isa_pkg::sext_field(instr.r.rb)
                                : regs[instr.r.rb];
   assign w_val = instr.r.w_imm ? silver_isa_pkg::sext_field(instr.r.rw)
                                : regs[instr.r.rw];
endmodule

/* hdl/silver_alu.sv */
// 16-function ALU of the silver core, combinational result with registered carry and overflow
`include "silver_macros.svh"

module silver_alu (
   input  logic                      clk,
   input  logic                      rst,
   input  silver_isa_pkg::alu_func_t func,
   input  logic [`SILVER_WORD-1:0]   in1,
   input  logic [`SILVER_WORD-1:0]   in2,
   input  logic                      flag_update,
   output logic [`SILVER_WORD-1:0]   result
);
   localparam int W = `SILVER_WORD;

   logic         carry;
   logic         overflow;
   logic         carry_in;
   logic [W:0]   sum;
   logic [W-1:0] diff;
   logic [2*W-1:0] prod;

   assign carry_in = (func == silver_isa_pkg::faddc) && carry;
   assign sum  = {1'b0, in1} + {1'b0, in2} + {{W{1'b0}}, carry_in};
   assign diff = in1 - in2;
   assign prod = {{W{1'b0}}, in1} * {{W{1'b0}}, in2};

   always_comb begin
      case (func)
         silver_isa_pkg::fadd,
         silver_isa_pkg::faddc:  result = sum[W-1:0];
         silver_isa_pkg::fsub:   result = diff;
         silver_isa_pkg::fcarry: result = W'(carry);
         silver_isa_pkg::fovf:   result = W'(overflow);
         silver_isa_pkg::finc:   result = in1 + 1'b1;
         silver_isa_pkg::fdec:   result = in1 - 1'b1;
         silver_isa_pkg::fmul:   result = prod[W-1:0];
         silver_isa_pkg::fmulhu: result = prod[2*W-1:W];
         silver_isa_pkg::fand:   result = in1 & in2;
         silver_isa_pkg::fior:   result = in1 | in2;
         silver_isa_pkg::fxor:   result = in1 ^ in2;
         silver_isa_pkg::feq:    result = W'(in1 == in2);
         silver_isa_pkg::fless:  result = W'($signed(in1) < $signed(in2));
         silver_isa_pkg::flower: result = W'(in1 < in2);
         default:                result = in2;  // fsnd
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         carry    <= 1'b0;
         overflow <= 1'b0;
      end else if (flag_update) begin
         case (func)
            silver_isa_pkg::fadd: begin
               carry    <= sum[W];
               overflow <= (in1[W-1] == in2[W-1]) && (sum[W-1] != in1[W-1]);
            end
            silver_isa_pkg::faddc: carry <= sum[W];
            silver_isa_pkg::fsub:
               overflow <= (in1[W-1] != in2[W-1]) && (diff[W-1] != in1[W-1]);
            default: ;
         endcase
      end
   end
endmodule

/* hdl/silver_isa_pkg.sv */
// silver instruction encodings and decode helpers, used by the core and its testbench
`include "silver_macros.svh"

package silver_isa_pkg;

   typedef enum logic [5:0] {
      op_normal     = 6'd0,
      op_store      = 6'd2,
      op_store_byte = 6'd3,
      op_load       = 6'd4,
      op_load_byte  = 6'd5,
      op_out        = 6'd6,
      op_jump       = 6'd9,
      op_jz         = 6'd10,
      op_jnz        = 6'd11,
      op_load_const = 6'd13,
      op_load_upper = 6'd14,
      op_nop        = 6'd15
   } opc_t;

   typedef enum logic [3:0] {
      fadd, faddc, fsub, fcarry, fovf, finc, fdec, fmul,
      fmulhu, fand, fior, fxor, feq, fless, flower, fsnd
   } alu_func_t;

   typedef struct packed {
      logic                     w_imm;
      logic [`SILVER_RADDR-1:0] rw;
      logic                     is_const;
      logic                     a_imm;
      logic [`SILVER_RADDR-1:0] ra;
      logic                     b_imm;
      logic [`SILVER_RADDR-1:0] rb;
      logic [3:0]               func;
      logic [5:0]               opc;
   } reg_fmt_t;

   typedef struct packed {
      logic                     w_imm;
      logic [`SILVER_RADDR-1:0] rw;
      logic                     is_const;
      logic                     neg;
      logic [22:0]              value;
   } const_fmt_t;

   typedef union packed {
      reg_fmt_t   r;
      const_fmt_t c;
   } instr_t;

   function automatic opc_t decode_opc(instr_t i);
      if (i.r.is_const) begin
         if (i.c.w_imm)
            return op_load_const;
         return (!i.c.neg && i.c.value[22:9] == '0) ? op_load_upper : op_nop;
      end
      case (i.r.opc)
         6'd0, 6'd2, 6'd3, 6'd4, 6'd5, 6'd6, 6'd9:
            return i.r.w_imm ? op_nop : opc_t'(i.r.opc);
         6'd10, 6'd11:
            return opc_t'(i.r.opc);
         default:
            return op_nop;  // shift, in, accelerator, interrupt, undefined
      endcase
   endfunction

   function automatic logic uses_func(opc_t o);
      return o inside {op_normal, op_out, op_jump, op_jz, op_jnz};
   endfunction

   function automatic logic [`SILVER_WORD-1:0] sext_field(logic [`SILVER_RADDR-1:0] f);
      return {{(`SILVER_WORD - `SILVER_RADDR){f[`SILVER_RADDR-1]}}, f};
   endfunction

endpackage

/* hdl/silver_macros.svh */
// widths and memory command codes shared by the silver core packages and RTL
`ifndef SILVER_MACROS_SVH
`define SILVER_MACROS_SVH

`define SILVER_WORD   32
`define SILVER_REGS   64
`define SILVER_RADDR  6
`define SILVER_OUT_W  10
`define SILVER_STRB   4

`define SILVER_CMD_W     3
`define SILVER_CMD_NONE  3'd0
`define SILVER_CMD_FETCH 3'd1
`define SILVER_CMD_READ  3'd2
`define SILVER_CMD_WRITE 3'd3

`endif

/* hdl/silver_mem_pkg.sv */
// memory bus command and load/store operation types, used by the core and its testbench
`include "silver_macros.svh"

package silver_mem_pkg;

   typedef enum logic [`SILVER_CMD_W-1:0] {
      cmd_none  = `SILVER_CMD_NONE,
      cmd_fetch = `SILVER_CMD_FETCH,
      cmd_read  = `SILVER_CMD_READ,
      cmd_write = `SILVER_CMD_WRITE
   } mem_cmd_t;

   typedef enum logic [1:0] {
      lsu_load_word,
      lsu_load_byte,
      lsu_store_word,
      lsu_store_byte
   } lsu_op_t;

endpackage

/* hdl/silver_sequencer.sv */
// multi-cycle control of the silver core: PC, instruction register, FSM and writeback
`include "silver_macros.svh"

module silver_sequencer (
   input  logic                      clk,
   input  logic                      rst,
   mem_bus_if.requester              fetch_bus,
   output silver_isa_pkg::instr_t    instr,
   input  logic [`SILVER_WORD-1:0]   a_val,
   input  logic [`SILVER_WORD-1:0]   b_val,
   input  logic [`SILVER_WORD-1:0]   w_val,
   output silver_isa_pkg::alu_func_t alu_func,
   output logic [`SILVER_WORD-1:0]   alu_in1,
   output logic [`SILVER_WORD-1:0]   alu_in2,
   output logic                      alu_flag_update,
   input  logic [`SILVER_WORD-1:0]   alu_result,
   output logic                      lsu_start,
   output silver_mem_pkg::lsu_op_t   lsu_op,
   input  logic                      lsu_done,
   input  logic [`SILVER_WORD-1:0]   load_data,
   output logic                      reg_we,
   output logic [`SILVER_WORD-1:0]   reg_wdata,
   output logic [`SILVER_OUT_W-1:0]  data_out
);
   localparam int W = `SILVER_WORD;

   typedef enum logic [2:0] {
      S_IDLE, S_FETCH, S_WAIT, S_EXEC, S_MEM, S_WB
   } state_t;

   state_t                 state;
   silver_isa_pkg::opc_t   opc;
   logic                   is_mem;
   logic [W-1:0]           pc;
   logic [W-1:0]           pc_plus4;
   logic [W-1:0]           pc_next;   // settled in execute
   logic [W-1:0]           res_q;     // alu result or load data
   logic [W-1:0]           const_val;

   assign opc      = silver_isa_pkg::decode_opc(instr);
   assign is_mem   = opc inside {silver_isa_pkg::op_load, silver_isa_pkg::op_load_byte,
                                 silver_isa_pkg::op_store, silver_isa_pkg::op_store_byte};
   assign pc_plus4 = pc + 3'd4;

   assign fetch_bus.command = (state == S_FETCH) ? silver_mem_pkg::cmd_fetch
                                                 : silver_mem_pkg::cmd_none;
   assign fetch_bus.addr  = pc;
   assign fetch_bus.wdata = '0;
   assign fetch_bus.wstrb = '0;

   assign alu_func = silver_isa_pkg::uses_func(opc) ? silver_isa_pkg::alu_func_t'(instr.r.func)
                                                    : silver_isa_pkg::fand;
   assign alu_in1  = (opc == silver_isa_pkg::op_jump) ? pc : a_val;
   assign alu_in2  = (opc == silver_isa_pkg::op_jump) ? a_val : b_val;
   assign alu_flag_update = state == S_EXEC;

   assign lsu_start = (state == S_EXEC) && is_mem;
   always_comb begin
      case (opc)
         silver_isa_pkg::op_load_byte:  lsu_op = silver_mem_pkg::lsu_load_byte;
         silver_isa_pkg::op_store:      lsu_op = silver_mem_pkg::lsu_store_word;
         silver_isa_pkg::op_store_byte: lsu_op = silver_mem_pkg::lsu_store_byte;
         default:                       lsu_op = silver_mem_pkg::lsu_load_word;
      endcase
   end

   assign const_val = {{(W - 23){1'b0}}, instr.c.value};
   assign reg_we = (state == S_WB) && (opc inside {
      silver_isa_pkg::op_normal, silver_isa_pkg::op_out, silver_isa_pkg::op_load,
      silver_isa_pkg::op_load_byte, silver_isa_pkg::op_jump,
      silver_isa_pkg::op_load_const, silver_isa_pkg::op_load_upper});

   always_comb begin
      case (opc)
         silver_isa_pkg::op_jump:       reg_wdata = pc_plus4;
         silver_isa_pkg::op_load_const: reg_wdata = instr.c.neg ? -const_val : const_val;
         silver_isa_pkg::op_load_upper: reg_wdata = {instr.c.value[8:0], w_val[22:0]};
         default:                       reg_wdata = res_q;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= S_IDLE;
         pc       <= '0;
         data_out <= '0;
      end else begin
         case (state)
            S_IDLE:  state <= S_FETCH;
            S_FETCH: state <= S_WAIT;
            S_WAIT:  if (fetch_bus.ready) state <= S_EXEC;
            S_EXEC:  state <= is_mem ? S_MEM : S_WB;
            S_MEM:   if (lsu_done) state <= S_WB;
            S_WB: begin
               state <= S_FETCH;
               pc    <= pc_next;
               if (opc == silver_isa_pkg::op_out)
                  data_out <= res_q[`SILVER_OUT_W-1:0];
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_WAIT && fetch_bus.ready)
         instr <= fetch_bus.rdata;
      if (state == S_EXEC) begin
         res_q <= alu_result;  // flags move at this edge, so keep the result
         if (opc == silver_isa_pkg::op_jump)
            pc_next <= alu_result;
         else if ((opc == silver_isa_pkg::op_jz && alu_result == '0) ||
                  (opc == silver_isa_pkg::op_jnz && alu_result != '0))
            pc_next <= pc + w_val;
         else
            pc_next <= pc_plus4;
      end
      if (state == S_MEM && lsu_done)
         res_q <= load_data;
   end

   assert property (@(posedge clk) disable iff (rst)
      state inside {S_IDLE, S_FETCH, S_WAIT, S_EXEC, S_MEM, S_WB});
endmodule

/* hdl/silver_top.sv */
// top level of the multi-cycle silver core, with plain memory bus and output ports
`include "silver_macros.svh"

module silver_top (
   input  logic                     clk,
   input  logic                     rst,
   output silver_mem_pkg::mem_cmd_t mem_command,
   output logic [`SILVER_WORD-1:0]  mem_addr,
   output logic [`SILVER_WORD-1:0]  mem_wdata,
   output logic [`SILVER_STRB-1:0]  mem_wstrb,
   input  logic                     mem_ready,
   input  logic [`SILVER_WORD-1:0]  mem_rdata,
   output logic [`SILVER_OUT_W-1:0] data_out
);
   mem_bus_if fetch_bus ();
   mem_bus_if data_bus ();

   silver_isa_pkg::instr_t    instr;
   silver_isa_pkg::alu_func_t alu_func;
   silver_mem_pkg::lsu_op_t   lsu_op;
   logic [`SILVER_WORD-1:0]   a_val;
   logic [`SILVER_WORD-1:0]   b_val;
   logic [`SILVER_WORD-1:0]   w_val;
   logic [`SILVER_WORD-1:0]   alu_in1;
   logic [`SILVER_WORD-1:0]   alu_in2;
   logic [`SILVER_WORD-1:0]   alu_result;
   logic [`SILVER_WORD-1:0]   load_data;
   logic [`SILVER_WORD-1:0]   reg_wdata;
   logic                      alu_flag_update;
   logic                      lsu_start;
   logic                      lsu_done;
   logic                      reg_we;

   silver_sequencer silver_sequencer_inst (
      .clk, .rst, .fetch_bus, .instr, .a_val, .b_val, .w_val,
      .alu_func, .alu_in1, .alu_in2, .alu_flag_update, .alu_result,
      .lsu_start, .lsu_op, .lsu_done, .load_data, .reg_we, .reg_wdata, .data_out
   );

   operand_fetch operand_fetch_inst (
      .clk, .rst, .instr, .reg_we, .reg_wdata, .a_val, .b_val, .w_val
   );

   silver_alu silver_alu_inst (
      .clk, .rst, .func(alu_func), .in1(alu_in1), .in2(alu_in2),
      .flag_update(alu_flag_update), .result(alu_result)
   );

   load_store_unit load_store_unit_inst (
      .clk, .rst, .start(lsu_start), .op(lsu_op), .a_val, .b_val,
      .done(lsu_done), .load_data, .bus(data_bus)
   );

   mem_arbiter mem_arbiter_inst (
      .clk, .rst, .fetch_bus, .data_bus, .mem_command, .mem_addr,
      .mem_wdata, .mem_wstrb, .mem_ready, .mem_rdata
   );
endmodule

/* test/silver_tb.sv */
// drives silver_top with random programs and checks each bus request against an instruction-level model
`include "silver_macros.svh"

module silver_tb;
   timeunit 1ns;
   timeprecision 1ps;

   typedef logic [`SILVER_WORD-1:0] word_t;

   localparam int mem_words   = 1024;
   localparam int num_instr   = 300;
   localparam int req_timeout = 20;  // cycles between two requests
   localparam logic [5:0] reg_opcodes [9] = '{6'd0, 6'd2, 6'd3, 6'd4, 6'd5, 6'd6, 6'd9,
                                              6'd10, 6'd11};

   logic                     clk = 1'b0;
   logic                     rst;
   silver_mem_pkg::mem_cmd_t mem_command;
   word_t                    mem_addr;
   word_t                    mem_wdata;
   logic [`SILVER_STRB-1:0]  mem_wstrb;
   logic                     mem_ready;
   word_t                    mem_rdata;
   logic [`SILVER_OUT_W-1:0] data_out;

   word_t                    mem [mem_words];
   word_t                    regs_m [`SILVER_REGS];
   word_t                    pc_m;
   logic [`SILVER_OUT_W-1:0] out_m;
   logic                     carry_m;
   logic                     ovf_m;

   silver_top silver_top_inst (.*);

   always #20 clk = ~clk;

   task automatic stop_run();
      $display("Result: FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic report_mismatch(input string name, input word_t got, input word_t exp);
      $display("** Error: %s is %h, expected %h (model pc %h)", name, got, exp, pc_m);
      stop_run();
   endtask

   task automatic check_request(input silver_mem_pkg::mem_cmd_t cmd, input word_t addr,
                                input word_t wdata, input logic [`SILVER_STRB-1:0] strb);
      if (mem_command !== cmd)
         report_mismatch("mem_command", mem_command, cmd);
      if (mem_addr !== addr)
         report_mismatch("mem_addr", mem_addr, addr);
      if (cmd == silver_mem_pkg::cmd_write && mem_wdata !== wdata)
         report_mismatch("mem_wdata", mem_wdata, wdata);  // data only matters for writes
      if (mem_wstrb !== strb)
         report_mismatch("mem_wstrb", mem_wstrb, strb);
   endtask

   task automatic check_out(input logic [`SILVER_OUT_W-1:0] val);
      if (data_out !== val)
         report_mismatch("data_out", data_out, val);
   endtask

   function automatic word_t gen_instr();
      word_t w;
      int    k;
      w = $urandom;
      k = $urandom_range(0, 10);
      if (k < 9) begin
         w[24]  = 1'b0;
         w[5:0] = reg_opcodes[k];
         if (k < 7)
            w[31] = 1'b0;  // conditional jumps keep a random wV flag
      end else begin
         w[24] = 1'b1;
         w[31] = (k == 9);
         if (k == 10)
            w[23:9] = '0;  // upper constant form
      end
      return w;
   endfunction

   function automatic word_t sext6(input logic [`SILVER_RADDR-1:0] f);
      return word_t'(signed'(f));
   endfunction

   function automatic silver_isa_pkg::opc_t decode_model(input silver_isa_pkg::instr_t i);
      if (i.r.is_const) begin
         if (i.c.w_imm)
            return silver_isa_pkg::op_load_const;
         else if (!i.c.neg && i.c.value[22:9] == '0)
            return silver_isa_pkg::op_load_upper;
         return silver_isa_pkg::op_nop;
      end
      if (i.r.opc inside {6'd10, 6'd11})
         return silver_isa_pkg::opc_t'(i.r.opc);
      if (i.r.opc inside {6'd0, 6'd2, 6'd3, 6'd4, 6'd5, 6'd6, 6'd9} && !i.r.w_imm)
         return silver_isa_pkg::opc_t'(i.r.opc);
      return silver_isa_pkg::op_nop;
   endfunction

   task automatic alu_model(input silver_isa_pkg::alu_func_t f, input word_t a,
                            input word_t b, output word_t r);
      logic [`SILVER_WORD:0]     s;
      logic [2*`SILVER_WORD-1:0] p;
      s = a + b + (f == silver_isa_pkg::faddc && carry_m);
      p = a * b;
      case (f)
         silver_isa_pkg::fadd, silver_isa_pkg::faddc: r = s[`SILVER_WORD-1:0];
         silver_isa_pkg::fsub:   r = a - b;
         silver_isa_pkg::fcarry: r = carry_m;
         silver_isa_pkg::fovf:   r = ovf_m;
         silver_isa_pkg::finc:   r = a + 1;
         silver_isa_pkg::fdec:   r = a - 1;
         silver_isa_pkg::fmul:   r = p[`SILVER_WORD-1:0];
         silver_isa_pkg::fmulhu: r = p[2*`SILVER_WORD-1:`SILVER_WORD];
         silver_isa_pkg::fand:   r = a & b;
         silver_isa_pkg::fior:   r = a | b;
         silver_isa_pkg::fxor:   r = a ^ b;
         silver_isa_pkg::feq:    r = (a == b);
         silver_isa_pkg::fless:  r = ($signed(a) < $signed(b));
         silver_isa_pkg::flower: r = (a < b);
         default:                r = b;
      endcase
      if (f == silver_isa_pkg::fadd || f == silver_isa_pkg::faddc)
         carry_m = s[`SILVER_WORD];
      if (f == silver_isa_pkg::fadd)
         ovf_m = (a[31] == b[31]) && (r[31] != a[31]);
      if (f == silver_isa_pkg::fsub)
         ovf_m = (a[31] != b[31]) && (r[31] != a[31]);
   endtask

   task automatic await_request();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (mem_command === silver_mem_pkg::cmd_none && n < req_timeout);
      if (mem_command === silver_mem_pkg::cmd_none) begin
         $display("no memory request arrived within %0d cycles, model pc %h", n, pc_m);
         stop_run();
      end
   endtask

   task automatic merge_write();
      for (int b = 0; b < `SILVER_STRB; b++)
         if (mem_wstrb[b])
            mem[mem_addr[11:2]][8*b +: 8] = mem_wdata[8*b +: 8];
   endtask

   task automatic respond(input word_t data);
      int d;
      d = $urandom_range(1, 4);
      repeat (d) @(posedge clk);
      #2;
      mem_ready = 1'b1;
      mem_rdata = data;
      @(posedge clk);
      #2;
      mem_ready = 1'b0;
   endtask

   task automatic step_instr();
      silver_isa_pkg::instr_t    i;
      silver_isa_pkg::opc_t      o;
      silver_isa_pkg::alu_func_t f;
      word_t av, bv, wv, res, nxt, rd, cval;
      await_request();
      check_request(silver_mem_pkg::cmd_fetch, pc_m, '0, '0);
      check_out(out_m);  // last Out result is visible by the next fetch
      i = mem[pc_m[11:2]];
      respond(i);
      o  = decode_model(i);
      av = i.r.a_imm ? sext6(i.r.ra) : regs_m[i.r.ra];
      bv = i.r.b_imm ? sext6(i.r.rb) : regs_m[i.r.rb];
      wv = i.r.w_imm ? sext6(i.r.rw) : regs_m[i.r.rw];
      f  = (o inside {silver_isa_pkg::op_normal, silver_isa_pkg::op_out, silver_isa_pkg::op_jump,
                      silver_isa_pkg::op_jz, silver_isa_pkg::op_jnz})
           ? silver_isa_pkg::alu_func_t'(i.r.func) : silver_isa_pkg::fand;
      if (o == silver_isa_pkg::op_jump)
         alu_model(f, pc_m, av, res);
      else
         alu_model(f, av, bv, res);
      nxt = pc_m + 4;
      if (o == silver_isa_pkg::op_jump)
         nxt = res;
      else if ((o == silver_isa_pkg::op_jz && res == '0) ||
               (o == silver_isa_pkg::op_jnz && res != '0))
         nxt = pc_m + wv;
      case (o)
         silver_isa_pkg::op_load, silver_isa_pkg::op_load_byte: begin
            await_request();
            check_request(silver_mem_pkg::cmd_read, av, '0, '0);
            rd = mem[av[11:2]];
            respond(rd);
            res = (o == silver_isa_pkg::op_load) ? rd : word_t'(rd[8*av[1:0] +: 8]);
         end
         silver_isa_pkg::op_store: begin
            await_request();
            check_request(silver_mem_pkg::cmd_write, bv, av, 4'b1111);
            merge_write();
            respond('0);
         end
         silver_isa_pkg::op_store_byte: begin
            await_request();
            check_request(silver_mem_pkg::cmd_write, bv, word_t'(av[7:0]) << (8 * bv[1:0]),
                          4'b0001 << bv[1:0]);
            merge_write();
            respond('0);
         end
         default: ;
      endcase
      cval = word_t'(i.c.value);
      case (o)
         silver_isa_pkg::op_normal, silver_isa_pkg::op_out,
         silver_isa_pkg::op_load, silver_isa_pkg::op_load_byte: regs_m[i.r.rw] = res;
         silver_isa_pkg::op_jump:       regs_m[i.r.rw] = pc_m + 4;
         silver_isa_pkg::op_load_const: regs_m[i.r.rw] = i.c.neg ? -cval : cval;
         silver_isa_pkg::op_load_upper:
            regs_m[i.r.rw] = {i.c.value[8:0], regs_m[i.r.rw][22:0]};
         default: ;
      endcase
      if (o == silver_isa_pkg::op_out)
         out_m = res[`SILVER_OUT_W-1:0];
      pc_m = nxt;
   endtask

   initial begin
      rst       = 1'b1;
      mem_ready = 1'b0;
      mem_rdata = '0;
      void'($urandom(32'h55a1858d));
      for (int a = 0; a < mem_words; a++)
         mem[a] = gen_instr();
      for (int r = 0; r < `SILVER_REGS; r++)
         regs_m[r] = '0;
      pc_m    = '0;
      out_m   = '0;
      carry_m = 1'b0;
      ovf_m   = 1'b0;
      repeat (3) @(posedge clk);
      #2;
      rst = 1'b0;
      @(negedge clk);
      if (mem_command !== silver_mem_pkg::cmd_none)
         report_mismatch("mem_command", mem_command, silver_mem_pkg::cmd_none);
      check_out('0);
      for (int n = 0; n < num_instr; n++)
         step_instr();
      // the fetch after the last instruction shows its pc and Out result
      await_request();
      check_request(silver_mem_pkg::cmd_fetch, pc_m, '0, '0);
      check_out(out_m);
      $display("Result: PASSED");
      $finish;
   end
endmodule
